// ==== loopback_patterns.txt ====
# S hh: byte sent on rx_i, hex
# E hh: byte expected next on tx_o, hex
S 00
E 00
S ff
E ff
S 55
E 55
S aa
E aa
S 01
E 01
S 80
E 80
S 7e
E 7e
S 3c
E 3c
S c3
E c3
S a5
E a5
S 5a
E 5a

// ==== tb.f ====
loopback_pkg.sv
clk_rst_gen.sv
attach_timer.sv
attach_fsm.sv
loopback_fifo.sv
usb_loopback.sv
tb_usb_loopback.sv

// ==== run_sim.sh ====
#!/usr/bin/env bash
# builds and runs the loopback testbench with verilator.

cd "$(dirname "$0")" || exit 1

LOG=sim.log

verilator --binary --timing --assert -Wno-fatal \
   --top-module tb_usb_loopback -f tb.f -o vtb_usb_loopback
if [ $? -ne 0 ]; then
   echo "verilator build failed"
   exit 1
fi

./obj_dir/vtb_usb_loopback 2>&1 | tee "$LOG"
if [ "${PIPESTATUS[0]}" -ne 0 ]; then
   echo "simulation exited with an error"
   exit 1
fi

if grep -q "Test OK" "$LOG"; then
   exit 0
fi

echo "pass message not found in $LOG"
exit 1

// ==== tb_usb_loopback.sv ====
`timescale 1ns/10ps

module tb_usb_loopback
   import loopback_pkg::*;
   ();

   localparam int PU_LIMIT = ATTACH_COUNT * TICK_DIV + 8;
   localparam int LED_LIMIT = DONE_COUNT * TICK_DIV + 8;
   localparam int RAND_BYTES = 200;

   logic    clk;
   logic    lock;
   stream_s rx_i;
   logic    rx_ready_o;
   stream_s tx_o;
   logic    tx_ready_i;
   logic    usb_pu_o;
   logic    led_o;

   byte_t       send_q[$];
   byte_t       exp_q[$];
   byte_t       pat_send[$];
   byte_t       pat_exp[$];
   logic [31:0] lfsr_state;
   logic        rx_take;
   int          occ;
   int          accepted;
   int          lock_cycles;
   int          errors;
   int          pass_cnt;
   int          fail_cnt;

   usb_loopback uut (
      .clk        (clk),
      .lock       (lock),
      .rx_i       (rx_i),
      .rx_ready_o (rx_ready_o),
      .tx_o       (tx_o),
      .tx_ready_i (tx_ready_i),
      .usb_pu_o   (usb_pu_o),
      .led_o      (led_o)
   );

   initial begin
      clk = 1'b0;
      forever #2 clk = ~clk;
   end

   // ####################################################################
   // random bits, x^32 + x^22 + x^2 + x + 1.
   // ####################################################################

   function automatic logic [31:0] lfsr_next(input logic [31:0] s);
      logic fb;
      fb = s[31] ^ s[21] ^ s[1] ^ s[0];
      return {s[30:0], fb};
   endfunction

   function automatic logic rand_bit();
      lfsr_state = lfsr_next(lfsr_state);
      return lfsr_state[0];
   endfunction

   function automatic byte_t rand_byte();
      byte_t b;
      b = '0;
      for (int i = 0; i < 8; i++) begin
         b = {b[6:0], rand_bit()};
      end
      return b;
   endfunction

   // 0 off, 1 on, 2 random.
   function automatic logic pick(input int mode);
      if (mode == 2) begin
         return rand_bit();
      end
      return (mode == 1);
   endfunction

   // ####################################################################
   // compare tasks.
   // ####################################################################

   task automatic check_byte(input string name, input byte_t exp, input byte_t act);
      if (exp !== act) begin
         $display("FAIL %s expected %h got %h", name, exp, act);
         errors++;
      end
   endtask

   task automatic check_bit(input string name, input logic exp, input logic act);
      if (exp !== act) begin
         $display("FAIL %s expected %h got %h", name, exp, act);
         errors++;
      end
   endtask

   task automatic check_level(input string name, input level_t exp, input level_t act);
      if (exp !== act) begin
         $display("FAIL %s expected %h got %h", name, exp, act);
         errors++;
      end
   endtask

   task automatic finish_test(input string name, input int mark);
      if (errors == mark) begin
         pass_cnt++;
         $display("test %s passed", name);
      end else begin
         fail_cnt++;
         $display("test %s failed with %0d errors", name, errors - mark);
      end
   endtask

   // ####################################################################
   // pattern file and lock.
   // ####################################################################

   task automatic load_patterns();
      int          fd;
      int          n;
      string       line;
      logic [7:0]  tag;
      byte_t       val;
      fd = $fopen("loopback_patterns.txt", "r");
      if (fd == 0) begin
         $display("could not open loopback_patterns.txt");
         errors++;
         return;
      end
      while (!$feof(fd)) begin
         n = $fgets(line, fd);
         if (n > 0) begin
            n = $sscanf(line, "%c %h", tag, val);
            if (n == 2 && tag == "S") begin
               pat_send.push_back(val);
            end else if (n == 2 && tag == "E") begin
               pat_exp.push_back(val);
            end
         end
      end
      $fclose(fd);
   endtask

   task automatic raise_lock();
      @(posedge clk);
      lock <= 1'b1;
      lock_cycles = 0;
   endtask

   task automatic wait_pullup();
      while (!usb_pu_o && lock_cycles < PU_LIMIT) begin
         @(negedge clk);
         lock_cycles++;
      end
      if (!usb_pu_o) begin
         $display("pull-up did not rise within %0d cycles of lock", PU_LIMIT);
         errors++;
      end
   endtask

   // ####################################################################
   // stream driver and scoreboard.
   // ####################################################################

   // drive on the rising edge, sample the handshake on the falling one.
   task automatic stream_cycle(input logic vld, input logic rdy);
      logic tx_take;
      @(posedge clk);
      if (!rx_i.valid || rx_take) begin
         if (vld && send_q.size() != 0) begin
            rx_i.data <= send_q.pop_front();
            rx_i.valid <= 1'b1;
         end else begin
            rx_i.valid <= 1'b0;
         end
      end
      tx_ready_i <= rdy;
      @(negedge clk);
      check_level("fifo level", level_t'(occ), uut.u_loopback_fifo.level_q);
      if (occ > FIFO_DEPTH) begin
         $display("more bytes stored than the fifo can hold: %0d", occ);
         errors++;
      end
      rx_take = rx_i.valid && rx_ready_o;
      tx_take = tx_o.valid && tx_ready_i;
      if (tx_take) begin
         if (exp_q.size() == 0) begin
            $display("tx_o delivered byte %h that was never sent", tx_o.data);
            errors++;
         end else begin
            check_byte("tx_o.data", exp_q.pop_front(), tx_o.data);
         end
         occ--;
      end
      if (rx_take) begin
         occ++;
         accepted++;
      end
   endtask

   task automatic run_stream(input int vld_mode, input int rdy_mode, input int limit);
      int   guard;
      logic v;
      logic r;
      guard = 0;
      while ((exp_q.size() != 0 || send_q.size() != 0) && guard < limit) begin
         v = pick(vld_mode);
         r = pick(rdy_mode);
         stream_cycle(v, r);
         guard++;
      end
      if (exp_q.size() != 0) begin
         $display("stream stalled with %0d bytes still expected", exp_q.size());
         errors++;
      end
   endtask

   // ####################################################################
   // tests.
   // ####################################################################

   initial begin
      byte_t b;
      int    guard;
      int    mark;
      lock = 1'b0;
      rx_i = '0;
      tx_ready_i = 1'b0;
      lfsr_state = 32'h13dcc71c;
      rx_take = 1'b0;
      occ = 0;
      accepted = 0;
      errors = 0;
      pass_cnt = 0;
      fail_cnt = 0;
      load_patterns();
      repeat (2) @(posedge clk);

      mark = errors;
      raise_lock();
      for (int i = 0; i < 3; i++) begin
         @(negedge clk);
         lock_cycles++;
         check_bit("usb_pu_o", 1'b0, usb_pu_o);
         check_bit("led_o", 1'b1, led_o);
         check_bit("rx_ready_o", 1'b0, rx_ready_o);
         check_bit("tx_o.valid", 1'b0, tx_o.valid);
      end
      finish_test("reset state", mark);

      mark = errors;
      wait_pullup();
      check_bit("led_o", 1'b1, led_o);
      check_bit("rx_ready_o", 1'b1, rx_ready_o);
      while (led_o && lock_cycles < LED_LIMIT) begin
         @(negedge clk);
         lock_cycles++;
      end
      if (led_o) begin
         $display("led did not go off within %0d cycles of lock", LED_LIMIT);
         errors++;
      end
      check_bit("usb_pu_o", 1'b1, usb_pu_o);
      finish_test("attach sequence", mark);

      mark = errors;
      if (pat_send.size() == 0) begin
         $display("pattern file held no bytes to send");
         errors++;
      end
      send_q = pat_send;
      exp_q = pat_exp;
      run_stream(1, 1, 20 * pat_send.size() + 20);
      finish_test("in-order echo", mark);

      // fifo fills while the host side stalls.
      mark = errors;
      accepted = 0;
      for (int i = 0; i < FIFO_DEPTH + 2; i++) begin
         b = rand_byte();
         send_q.push_back(b);
         exp_q.push_back(b);
      end
      guard = 0;
      while (rx_ready_o && guard < 4 * FIFO_DEPTH) begin
         stream_cycle(1'b1, 1'b0);
         guard++;
      end
      check_bit("rx_ready_o", 1'b0, rx_ready_o);
      check_level("accepted bytes", level_t'(FIFO_DEPTH), level_t'(accepted));
      repeat (4) stream_cycle(1'b1, 1'b0);
      check_level("accepted bytes", level_t'(FIFO_DEPTH), level_t'(accepted));
      check_bit("tx_o.valid", 1'b1, tx_o.valid);
      run_stream(1, 1, 20 * FIFO_DEPTH);
      check_bit("rx_ready_o", 1'b1, rx_ready_o);
      finish_test("back-pressure", mark);

      mark = errors;
      for (int i = 0; i < RAND_BYTES; i++) begin
         b = rand_byte();
         send_q.push_back(b);
         exp_q.push_back(b);
      end
      run_stream(2, 2, 40 * RAND_BYTES);
      finish_test("random handshakes", mark);

      mark = errors;
      accepted = 0;
      for (int i = 0; i < 6; i++) begin
         send_q.push_back(byte_t'(8'h10 + i));
      end
      guard = 0;
      while (accepted < 4 && guard < 40) begin
         stream_cycle(1'b1, 1'b0);
         guard++;
      end
      if (accepted < 4) begin
         $display("only %0d bytes were accepted before lock was dropped", accepted);
         errors++;
      end
      check_bit("tx_o.valid", 1'b1, tx_o.valid);
      @(posedge clk);
      lock <= 1'b0;
      rx_i <= '0;
      tx_ready_i <= 1'b0;
      @(negedge clk);
      check_bit("usb_pu_o", 1'b0, usb_pu_o);
      check_bit("rx_ready_o", 1'b0, rx_ready_o);
      check_bit("tx_o.valid", 1'b0, tx_o.valid);
      check_bit("led_o", 1'b1, led_o);
      send_q.delete();
      exp_q.delete();
      occ = 0;
      rx_take = 1'b0;
      repeat (2) @(posedge clk);
      raise_lock();
      wait_pullup();
      check_bit("rx_ready_o", 1'b1, rx_ready_o);
      // fresh bytes only, nothing stale may come out first.
      for (int i = 0; i < 5; i++) begin
         send_q.push_back(byte_t'(8'hc0 + i));
         exp_q.push_back(byte_t'(8'hc0 + i));
      end
      run_stream(1, 1, 100);
      finish_test("lock loss", mark);

      $display("tests passed: %0d, failed: %0d", pass_cnt, fail_cnt);
      if (fail_cnt == 0 && errors == 0) begin
         $display("Test OK");
      end else begin
         $display("Test FAILED");
      end
      $finish;
   end

endmodule

// ==== usb_loopback.sv ====
`timescale 1ns/10ps

module usb_loopback
   import loopback_pkg::*;
   (
   input  logic    clk,
   input  logic    lock,
   input  stream_s rx_i,
   output logic    rx_ready_o,
   output stream_s tx_o,
   input  logic    tx_ready_i,
   output logic    usb_pu_o,
   output logic    led_o
   );

   logic rstn;
   logic tick;
   logic attach_hit;
   logic path_en;

   // ####################################################################
   // reset and tick.
   // ####################################################################

   clk_rst_gen u_clk_rst_gen (
      .clk    (clk),
      .lock   (lock),
      .rstn_o (rstn),
      .tick_o (tick)
   );

   // ####################################################################
   // attach.
   // ####################################################################

   attach_timer u_attach_timer (
      .clk          (clk),
      .rstn_i       (rstn),
      .tick_i       (tick),
      .attach_hit_o (attach_hit),
      .led_o        (led_o)
   );

   attach_fsm u_attach_fsm (
      .clk          (clk),
      .rstn_i       (rstn),
      .attach_hit_i (attach_hit),
      .usb_pu_o     (usb_pu_o),
      .path_en_o    (path_en)
   );

   // ####################################################################
   // echo path.
   // ####################################################################

   // stands in for the usb class core.
   loopback_fifo u_loopback_fifo (
      .clk        (clk),
      .rstn_i     (rstn),
      .en_i       (path_en),
      .rx_i       (rx_i),
      .rx_ready_o (rx_ready_o),
      .tx_o       (tx_o),
      .tx_ready_i (tx_ready_i)
   );

endmodule

// ==== loopback_fifo.sv ====
`timescale 1ns/10ps

module loopback_fifo
   import loopback_pkg::*;
   (
   input  logic    clk,
   input  logic    rstn_i,
   input  logic    en_i,
   input  stream_s rx_i,
   output logic    rx_ready_o,
   output stream_s tx_o,
   input  logic    tx_ready_i
   );

   byte_t  mem [FIFO_DEPTH];
   ptr_t   wr_ptr;
   ptr_t   rd_ptr;
   level_t level_q;
   level_t rd_avail;
   logic   wr_q;
   logic   full;
   logic   empty;
   logic   wr_en;
   logic   rd_en;

   // ####################################################################
   // status.
   // ####################################################################

   assign full = (level_q == level_t'(FIFO_DEPTH));

   // last written byte becomes readable one cycle later.
   assign rd_avail = level_q - level_t'(wr_q);
   assign empty = (rd_avail == '0);

   assign rx_ready_o = en_i && !full;
   assign tx_o.valid = en_i && !empty;
   assign tx_o.data = mem[rd_ptr];

   assign wr_en = rx_i.valid && rx_ready_o;
   assign rd_en = tx_o.valid && tx_ready_i;

   // ####################################################################
   // storage.
   // ####################################################################

   always_ff @(posedge clk) begin
      if (wr_en) begin
         mem[wr_ptr] <= rx_i.data;
      end
   end

   // depth is a power of two, pointers wrap by themselves.
   always_ff @(posedge clk or negedge rstn_i) begin
      if (!rstn_i) begin
         wr_ptr <= '0;
         rd_ptr <= '0;
         level_q <= '0;
         wr_q <= 1'b0;
      end else begin
         wr_q <= wr_en;
         if (wr_en) begin
            wr_ptr <= wr_ptr + 1'b1;
         end
         if (rd_en) begin
            rd_ptr <= rd_ptr + 1'b1;
         end
         case ({wr_en, rd_en})
            2'b10: level_q <= level_q + 1'b1;
            2'b01: level_q <= level_q - 1'b1;
            default: level_q <= level_q;
         endcase
      end
   end

   // ####################################################################
   // checks.
   // ####################################################################

   a_no_overflow: assert property (@(posedge clk) disable iff (!rstn_i)
      wr_en |-> (level_q < level_t'(FIFO_DEPTH)));

   a_no_underflow: assert property (@(posedge clk) disable iff (!rstn_i)
      rd_en |-> (level_q != '0));

endmodule

// ==== attach_fsm.sv ====
`timescale 1ns/10ps

module attach_fsm
   import loopback_pkg::*;
   (
   input  logic clk,
   input  logic rstn_i,
   input  logic attach_hit_i,
   output logic usb_pu_o,
   output logic path_en_o
   );

   attach_state_e state_q;
   attach_state_e state_d;
   logic          usb_pu_q;
   logic          path_en_q;

   // ####################################################################
   // next state.
   // ####################################################################

   always_comb begin
      state_d = state_q;
      case (state_q)
         ST_RESET: begin
            state_d = ST_WAIT_ATTACH;
         end
         ST_WAIT_ATTACH: begin
            if (attach_hit_i) begin
               state_d = ST_ATTACHED;
            end
         end
         ST_ATTACHED: begin
            state_d = ST_ATTACHED;
         end
         default: begin
            state_d = ST_RESET;
         end
      endcase
   end

   // ####################################################################
   // state and output registers.
   // ####################################################################

   always_ff @(posedge clk or negedge rstn_i) begin
      if (!rstn_i) begin
         state_q <= ST_RESET;
         usb_pu_q <= 1'b0;
         path_en_q <= 1'b0;
      end else begin
         state_q <= state_d;
         // set on entry, held until reset.
         if (state_d == ST_ATTACHED) begin
            usb_pu_q <= 1'b1;
            path_en_q <= 1'b1;
         end
      end
   end

   assign usb_pu_o = usb_pu_q;
   assign path_en_o = path_en_q;

   // no data before the host can see the device.
   a_en_needs_pu: assert property (@(posedge clk) disable iff (!rstn_i)
      path_en_o |-> usb_pu_o);

endmodule

// ==== attach_timer.sv ====
`timescale 1ns/10ps

module attach_timer
   import loopback_pkg::*;
   (
   input  logic clk,
   input  logic rstn_i,
   input  logic tick_i,
   output logic attach_hit_o,
   output logic led_o
   );

   tick_cnt_t up_cnt;
   logic      cnt_done;

   assign cnt_done = (up_cnt >= tick_cnt_t'(DONE_COUNT));

   // saturating tick counter.
   always_ff @(posedge clk or negedge rstn_i) begin
      if (!rstn_i) begin
         up_cnt <= '0;
      end else begin
         if (tick_i && !cnt_done) begin
            up_cnt <= up_cnt + 1'b1;
         end
      end
   end

   // pull-up milestone, stays high once reached.
   assign attach_hit_o = (up_cnt >= tick_cnt_t'(ATTACH_COUNT));

   // led on while attaching.
   assign led_o = !cnt_done;

   a_cnt_bound: assert property (@(posedge clk) disable iff (!rstn_i)
      up_cnt <= tick_cnt_t'(DONE_COUNT));

endmodule

// ==== clk_rst_gen.sv ====
`timescale 1ns/10ps

module clk_rst_gen
   import loopback_pkg::*;
   (
   input  logic clk,
   input  logic lock,
   output logic rstn_o,
   output logic tick_o
   );

   logic [1:0]       rstn_sync;
   logic [DIV_W-1:0] div_cnt;

   // ####################################################################
   // reset synchronizer.
   // ####################################################################

   // asserts at once on lock loss, releases on the second edge.
   always_ff @(posedge clk or negedge lock) begin
      if (!lock) begin
         rstn_sync <= 2'b00;
      end else begin
         rstn_sync <= {rstn_sync[0], 1'b1};
      end
   end

   assign rstn_o = rstn_sync[1];

   // ####################################################################
   // tick prescaler.
   // ####################################################################

   always_ff @(posedge clk or negedge rstn_o) begin
      if (!rstn_o) begin
         div_cnt <= DIV_W'(TICK_DIV - 1);
         tick_o <= 1'b0;
      end else begin
         tick_o <= (div_cnt == '0);
         if (div_cnt == '0) begin
            div_cnt <= DIV_W'(TICK_DIV - 1);
         end else begin
            div_cnt <= div_cnt - 1'b1;
         end
      end
   end

   // tick is a strobe.
   a_tick_single: assert property (@(posedge clk) disable iff (!rstn_o)
      tick_o |=> !tick_o);

endmodule

// ==== loopback_pkg.sv ====
package loopback_pkg;

   // ####################################################################
   // timing constants.
   // ####################################################################

   // clk cycles per tick.
   localparam int TICK_DIV = 16;
   localparam int DIV_W = $clog2(TICK_DIV);

   // attach counter, shortened for simulation.
   localparam int CNT_W = 8;
   localparam int ATTACH_COUNT = 32;
   localparam int DONE_COUNT = 128;

   // ####################################################################
   // byte fifo.
   // ####################################################################

   localparam int FIFO_DEPTH = 8;
   localparam int PTR_W = $clog2(FIFO_DEPTH);

   // ####################################################################
   // types.
   // ####################################################################

   typedef logic [7:0] byte_t;
   typedef logic [CNT_W-1:0] tick_cnt_t;
   typedef logic [PTR_W-1:0] ptr_t;
   typedef logic [PTR_W:0] level_t;

   // one byte stream, ready travels the other way.
   typedef struct packed {
      byte_t data;
      logic  valid;
   } stream_s;

   typedef enum logic [1:0] {
      ST_RESET,
      ST_WAIT_ATTACH,
      ST_ATTACHED
   } attach_state_e;

endpackage
